//--- Makefile
TOP := uart_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- bench/uart_chk.sv
`timescale 1ns/1ps

module uart_chk import uart_pkg::*; (
   input logic clk_i,
   input logic reset_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_o,
   input logic pslverr_o,
   input logic tx_idle_i,
   input logic uart_txd_o
);

   // Zero wait states on every access
   pready_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
      psel_i && penable_i |-> pready_o)
      else $error("pready_o low during an APB access");

   // Slave error only in the access phase
   pslverr_in_access: assert property (@(posedge clk_i) disable iff (reset_i)
      pslverr_o |-> psel_i && penable_i)
      else $error("pslverr_o high outside an APB access");

   // Idle line is a mark
   txd_high_when_idle: assert property (@(posedge clk_i) disable iff (reset_i)
      tx_idle_i |-> uart_txd_o)
      else $error("uart_txd_o low while the transmitter is idle");

endmodule

bind uart_top uart_chk chk (
   .clk_i     (clk_i),
   .reset_i   (reset_i),
   .psel_i    (psel_i),
   .penable_i (penable_i),
   .pready_o  (pready_o),
   .pslverr_o (pslverr_o),
   .tx_idle_i (tx_ready),
   .uart_txd_o(uart_txd_o)
);

//--- bench/uart_tb.sv
`timescale 1ns/1ps

module uart_tb import uart_pkg::*;;

   logic                  clk_i;
   logic                  reset_i;
   logic [APB_ADDR_W-1:0] paddr_i;
   logic                  psel_i;
   logic                  penable_i;
   logic                  pwrite_i;
   logic [APB_DATA_W-1:0] pwdata_i;
   logic [APB_DATA_W-1:0] prdata_o;
   logic                  pready_o;
   logic                  pslverr_o;
   logic                  uart_rxd_i;
   logic                  uart_txd_o;

   // Serial mux selects loopback or a tb-driven line
   logic inject_en;
   logic inject_line;

   logic [15:0] lfsr_q;
   int          div_cur;
   int          errors;
   int          test_errs;
   int          failed_tests;

   assign uart_rxd_i = inject_en ? inject_line : uart_txd_o;

   uart_top DUT (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .paddr_i   (paddr_i),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .uart_rxd_i(uart_rxd_i),
      .uart_txd_o(uart_txd_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %s: got 0x%h expected 0x%h", name, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      errors++;
      test_errs++;
   endtask

   // Setup and access cycles with side effects at the closing edge
   task automatic apb_transfer(input logic [APB_ADDR_W-1:0] addr, input logic wr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
      logic err_exp;
      @(posedge clk_i);
      paddr_i   <= addr;
      pwrite_i  <= wr;
      pwdata_i  <= wdata;
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(negedge clk_i);
      rdata   = prdata_o;
      err_exp = !(addr == ADDR_DATA || addr == ADDR_STATUS || addr == ADDR_DIV);
      compare("pslverr_o", 32'(pslverr_o), 32'(err_exp));
      compare("pready_o", 32'(pready_o), 32'd1);
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      apb_transfer(addr, 1'b1, data, unused);
   endtask

   task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
      apb_transfer(addr, 1'b0, 32'd0, data);
   endtask

   task automatic wait_status(input int bit_pos, input string what);
      logic [31:0] st;
      int          n;
      st = '0;
      n  = 0;
      while (!st[bit_pos] && n < 20 * div_cur) begin
         read_reg(ADDR_STATUS, st);
         n++;
      end
      if (!st[bit_pos]) begin
         report_timeout(what);
      end
   endtask

   // Drives one frame on the rx line, then holds the line idle
   task automatic inject_frame(input logic [7:0] b, input logic stop);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int k = 0; k < 10; k++) begin
         for (int c = 0; c < div_cur; c++) begin
            @(posedge clk_i);
            inject_line <= bits[k];
         end
      end
      for (int c = 0; c < 2 * div_cur; c++) begin
         @(posedge clk_i);
         inject_line <= 1'b1;
      end
   endtask

   // Monitor checks that every cycle of a bit matches its first cycle
   task automatic decode_frame(output logic [7:0] b);
      logic [9:0] bits;
      logic       seen;
      logic       level;
      int         n;
      int         glitches;
      bits     = '1;
      seen     = 1'b0;
      level    = 1'b1;
      n        = 0;
      glitches = 0;
      while (!seen && n < 16 * div_cur + 64) begin
         @(negedge clk_i);
         seen = !uart_txd_o;
         n++;
      end
      if (!seen) begin
         report_timeout("a start bit on uart_txd_o");
      end else begin
         for (int k = 0; k < 10; k++) begin
            for (int c = 0; c < div_cur; c++) begin
               if (k != 0 || c != 0) begin
                  @(negedge clk_i);
               end
               if (c == 0) begin
                  level = uart_txd_o;
               end else if (uart_txd_o !== level) begin
                  glitches++;
               end
               if (c == div_cur / 2) begin
                  bits[k] = uart_txd_o;
               end
            end
         end
         compare("uart_txd_o start bit", 32'(bits[0]), 32'd0);
         compare("uart_txd_o stop bit", 32'(bits[9]), 32'd1);
         compare("uart_txd_o bit length errors", 32'(glitches), 32'd0);
      end
      b = bits[8:1];
   endtask

   task automatic reset_and_map();
      logic [31:0] rd;
      read_reg(ADDR_STATUS, rd);
      compare("prdata_o STATUS", rd, 32'd1 << ST_TX_EMPTY);
      read_reg(ADDR_DIV, rd);
      compare("prdata_o DIV", rd, 32'd16);
      read_reg(ADDR_DATA, rd);
      compare("prdata_o DATA", rd, 32'd0);
      write_reg(4'hC, 32'hFFFF_FFFF);
      read_reg(4'hC, rd);
      read_reg(ADDR_STATUS, rd);
      compare("prdata_o STATUS", rd, 32'd1 << ST_TX_EMPTY);
      read_reg(ADDR_DIV, rd);
      compare("prdata_o DIV", rd, 32'd16);
   endtask

   task automatic div_readback();
      logic [31:0] rd;
      logic [31:0] v;
      v = rand_bits(16);
      write_reg(ADDR_DIV, v);
      read_reg(ADDR_DIV, rd);
      compare("prdata_o DIV", rd, (v < 32'd4) ? 32'd4 : v);
      write_reg(ADDR_DIV, 32'd2);
      read_reg(ADDR_DIV, rd);
      compare("prdata_o DIV", rd, 32'd4);
      // Short bit period for the serial tests
      div_cur = 4 + int'(rand_bits(3));
      write_reg(ADDR_DIV, 32'(div_cur));
      read_reg(ADDR_DIV, rd);
      compare("prdata_o DIV", rd, 32'(div_cur));
   endtask

   task automatic tx_framing();
      logic [7:0] tx_bytes [4];
      logic [7:0] got;
      for (int i = 0; i < 4; i++) begin
         tx_bytes[i] = 8'(rand_bits(8));
      end
      fork
         begin
            for (int i = 0; i < 4; i++) begin
               write_reg(ADDR_DATA, 32'(tx_bytes[i]));
            end
         end
         begin
            for (int i = 0; i < 4; i++) begin
               decode_frame(got);
               compare("uart_txd_o byte", 32'(got), 32'(tx_bytes[i]));
            end
         end
      join
   endtask

   task automatic loopback_receive();
      logic [7:0]  sent [3];
      logic [31:0] rd;
      @(posedge clk_i);
      inject_en <= 1'b0;
      for (int i = 0; i < 3; i++) begin
         sent[i] = 8'(rand_bits(8));
         write_reg(ADDR_DATA, 32'(sent[i]));
      end
      for (int i = 0; i < 3; i++) begin
         wait_status(ST_RX_VALID, "RX_VALID in loopback");
         read_reg(ADDR_DATA, rd);
         compare("prdata_o DATA", rd, 32'(sent[i]));
      end
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.RX_VALID", 32'(rd[ST_RX_VALID]), 32'd0);
      inject_en <= 1'b1;
   endtask

   task automatic back_pressure();
      logic [7:0]  rx_bytes [6];
      logic [31:0] rd;
      int          drops;
      write_reg(ADDR_DIV, 32'd200);
      for (int i = 0; i < 6; i++) begin
         write_reg(ADDR_DATA, rand_bits(8));
      end
      // Transmitter holds one byte and the FIFO the next four
      drops = 6 - 1 - FIFO_DEPTH;
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.TX_DROP", 32'(rd[ST_TX_DROP]), 32'(drops > 0));
      compare("STATUS.TX_FULL", 32'(rd[ST_TX_FULL]), 32'd1);
      write_reg(ADDR_DIV, 32'(div_cur));
      for (int i = 0; i < 6; i++) begin
         rx_bytes[i] = 8'(rand_bits(8));
         inject_frame(rx_bytes[i], 1'b1);
      end
      wait_status(ST_RX_OVERRUN, "RX_OVERRUN");
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.RX_VALID", 32'(rd[ST_RX_VALID]), 32'd1);
      write_reg(ADDR_STATUS, (32'd1 << ST_RX_OVERRUN) | (32'd1 << ST_TX_DROP));
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.RX_OVERRUN", 32'(rd[ST_RX_OVERRUN]), 32'd0);
      compare("STATUS.TX_DROP", 32'(rd[ST_TX_DROP]), 32'd0);
      // Only the oldest bytes were kept
      for (int i = 0; i < FIFO_DEPTH; i++) begin
         read_reg(ADDR_DATA, rd);
         compare("prdata_o DATA", rd, 32'(rx_bytes[i]));
      end
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.RX_VALID", 32'(rd[ST_RX_VALID]), 32'd0);
   endtask

   task automatic framing_error();
      logic [31:0] rd;
      inject_frame(8'(rand_bits(8)), 1'b0);
      wait_status(ST_FRAME_ERR, "FRAME_ERR");
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.RX_VALID", 32'(rd[ST_RX_VALID]), 32'd0);
      write_reg(ADDR_STATUS, 32'd1 << ST_FRAME_ERR);
      read_reg(ADDR_STATUS, rd);
      compare("STATUS.FRAME_ERR", 32'(rd[ST_FRAME_ERR]), 32'd0);
   endtask

   task automatic report_test(input string name);
      if (test_errs == 0) begin
         $display("%-20s ok", name);
      end else begin
         $display("%-20s %0d errors", name, test_errs);
         failed_tests++;
      end
      test_errs = 0;
   endtask

   initial begin
      lfsr_q       = 16'd34790;
      div_cur      = 16;
      errors       = 0;
      test_errs    = 0;
      failed_tests = 0;
      reset_i     <= 1'b1;
      paddr_i     <= '0;
      psel_i      <= 1'b0;
      penable_i   <= 1'b0;
      pwrite_i    <= 1'b0;
      pwdata_i    <= '0;
      inject_en   <= 1'b1;
      inject_line <= 1'b1;
      repeat (3) @(posedge clk_i);
      reset_i <= 1'b0;

      reset_and_map();
      report_test("reset and map");
      div_readback();
      report_test("div readback");
      tx_framing();
      report_test("tx framing");
      loopback_receive();
      report_test("loopback receive");
      back_pressure();
      report_test("back-pressure");
      framing_error();
      report_test("framing error");

      $display("6 tests run, %0d failed, %0d errors", failed_tests, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- common/uart_pkg.sv
package uart_pkg;

   // Character and bus widths
   localparam int DATA_W     = 8;
   localparam int APB_ADDR_W = 4;
   localparam int APB_DATA_W = 32;

   // Register map
   localparam logic [APB_ADDR_W-1:0] ADDR_DATA   = 4'h0;
   localparam logic [APB_ADDR_W-1:0] ADDR_STATUS = 4'h4;
   localparam logic [APB_ADDR_W-1:0] ADDR_DIV    = 4'h8;

   // Bit period divisor
   localparam int               DIV_W     = 16;
   localparam logic [DIV_W-1:0] DIV_MIN   = 16'd4;
   localparam logic [DIV_W-1:0] DIV_RESET = 16'd16;

   // Byte queues
   localparam int FIFO_DEPTH = 4;
   localparam int FIFO_PTR_W = 2;

   // STATUS field positions with the live flags below the sticky ones
   localparam int ST_TX_FULL    = 0;
   localparam int ST_TX_EMPTY   = 1;
   localparam int ST_RX_VALID   = 2;
   localparam int ST_RX_OVERRUN = 3;
   localparam int ST_FRAME_ERR  = 4;
   localparam int ST_TX_DROP    = 5;

   // Frame is start, 8 data, stop
   localparam int FRAME_BITS = 10;
   localparam int TX_BIT_W   = 4;
   localparam int RX_BIT_W   = 3;

   // Receiver states
   localparam int             RX_ST_W  = 3;
   localparam logic [RX_ST_W-1:0] RX_IDLE  = 3'd0;
   localparam logic [RX_ST_W-1:0] RX_START = 3'd1;
   localparam logic [RX_ST_W-1:0] RX_DATA  = 3'd2;
   localparam logic [RX_ST_W-1:0] RX_STOP  = 3'd3;
   localparam logic [RX_ST_W-1:0] RX_WAIT  = 3'd4;

endpackage

//--- compile.f
common/uart_pkg.sv
src/uart_fifo.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
src/uart_apb_regs.sv
src/uart_top.sv
bench/uart_chk.sv
bench/uart_tb.sv

//--- src/uart_apb_regs.sv
`timescale 1ns/1ps

module uart_apb_regs import uart_pkg::*; (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [APB_DATA_W-1:0] pwdata_i,
   input  logic [DATA_W-1:0]     rx_head_i,
   input  logic                  rx_empty_i,
   input  logic                  rx_full_i,
   input  logic                  rx_push_i,
   input  logic                  frame_err_i,
   input  logic                  tx_full_i,
   input  logic                  tx_empty_i,
   output logic [APB_DATA_W-1:0] prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   output logic                  rx_pop_o,
   output logic                  tx_push_o,
   output logic [DATA_W-1:0]     tx_byte_o,
   output logic [DIV_W-1:0]      div_o
);

   logic                  access;
   logic                  mapped;
   logic                  wr_ok;
   logic                  hit_data;
   logic                  hit_status;
   logic                  hit_div;
   logic [DIV_W-1:0]      div_q;
   logic [DIV_W-1:0]      div_wr;
   logic                  rx_overrun;
   logic                  frame_err;
   logic                  tx_drop;
   logic [APB_DATA_W-1:0] status_w;

   assign access     = psel_i && penable_i;
   assign hit_data   = (paddr_i == ADDR_DATA);
   assign hit_status = (paddr_i == ADDR_STATUS);
   assign hit_div    = (paddr_i == ADDR_DIV);
   assign mapped     = hit_data || hit_status || hit_div;
   assign wr_ok      = access && pwrite_i && mapped;

   // Zero wait states
   assign pready_o  = 1'b1;
   assign pslverr_o = access && !mapped;

   assign tx_push_o = wr_ok && hit_data;
   assign tx_byte_o = pwdata_i[DATA_W-1:0];
   assign rx_pop_o  = access && !pwrite_i && hit_data && !rx_empty_i;

   // Too small a divisor cannot place a mid-bit sample
   assign div_wr = (pwdata_i[DIV_W-1:0] < DIV_MIN) ? DIV_MIN : pwdata_i[DIV_W-1:0];
   assign div_o  = div_q;

   always_comb begin
      status_w                = '0;
      status_w[ST_TX_FULL]    = tx_full_i;
      status_w[ST_TX_EMPTY]   = tx_empty_i;
      status_w[ST_RX_VALID]   = !rx_empty_i;
      status_w[ST_RX_OVERRUN] = rx_overrun;
      status_w[ST_FRAME_ERR]  = frame_err;
      status_w[ST_TX_DROP]    = tx_drop;
   end

   always_comb begin
      prdata_o = '0;
      if (psel_i && !pwrite_i) begin
         if (hit_data && !rx_empty_i) begin
            prdata_o[DATA_W-1:0] = rx_head_i;
         end else if (hit_status) begin
            prdata_o = status_w;
         end else if (hit_div) begin
            prdata_o[DIV_W-1:0] = div_q;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         div_q      <= DIV_RESET;
         rx_overrun <= 1'b0;
         frame_err  <= 1'b0;
         tx_drop    <= 1'b0;
      end else begin
         if (wr_ok && hit_div) begin
            div_q <= div_wr;
         end
         // A new event wins over a clear in the same cycle
         if (rx_push_i && rx_full_i) begin
            rx_overrun <= 1'b1;
         end else if (wr_ok && hit_status && pwdata_i[ST_RX_OVERRUN]) begin
            rx_overrun <= 1'b0;
         end
         if (frame_err_i) begin
            frame_err <= 1'b1;
         end else if (wr_ok && hit_status && pwdata_i[ST_FRAME_ERR]) begin
            frame_err <= 1'b0;
         end
         if (tx_push_o && tx_full_i) begin
            tx_drop <= 1'b1;
         end else if (wr_ok && hit_status && pwdata_i[ST_TX_DROP]) begin
            tx_drop <= 1'b0;
         end
      end
   end

endmodule

//--- src/uart_fifo.sv
`timescale 1ns/1ps

module uart_fifo import uart_pkg::*; (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              push_i,
   input  logic [DATA_W-1:0] data_i,
   input  logic              pop_i,
   output logic [DATA_W-1:0] data_o,
   output logic              empty_o,
   output logic              full_o
);

   logic [DATA_W-1:0]     mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_PTR_W:0]   count;
   logic                  do_push;
   logic                  do_pop;

   assign empty_o = (count == '0);
   assign full_o  = (count == (FIFO_PTR_W+1)'(FIFO_DEPTH));

   // Push on full is dropped here, the producer flags it
   assign do_push = push_i && !full_o;
   assign do_pop  = pop_i && !empty_o;

   assign data_o = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= data_i;
      end
   end

endmodule

//--- src/uart_top.sv
`timescale 1ns/1ps

module uart_top import uart_pkg::*; (
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [APB_DATA_W-1:0] pwdata_i,
   output logic [APB_DATA_W-1:0] prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   input  logic                  uart_rxd_i,
   output logic                  uart_txd_o
);

   logic [DATA_W-1:0] rx_byte;
   logic              rx_push;
   logic              frame_err;
   logic [DATA_W-1:0] rx_head;
   logic              rx_empty;
   logic              rx_full;
   logic              rx_pop;
   logic              tx_push;
   logic [DATA_W-1:0] tx_byte;
   logic [DATA_W-1:0] tx_head;
   logic              tx_empty;
   logic              tx_full;
   logic              tx_ready;
   logic              tx_pop;
   logic [DIV_W-1:0]  div;

   // Byte moves to the transmitter when it is idle
   assign tx_pop = !tx_empty && tx_ready;

   uart_apb_regs regs (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .paddr_i    (paddr_i),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .pwdata_i   (pwdata_i),
      .rx_head_i  (rx_head),
      .rx_empty_i (rx_empty),
      .rx_full_i  (rx_full),
      .rx_push_i  (rx_push),
      .frame_err_i(frame_err),
      .tx_full_i  (tx_full),
      .tx_empty_i (tx_empty),
      .prdata_o   (prdata_o),
      .pready_o   (pready_o),
      .pslverr_o  (pslverr_o),
      .rx_pop_o   (rx_pop),
      .tx_push_o  (tx_push),
      .tx_byte_o  (tx_byte),
      .div_o      (div)
   );

   uart_fifo rx_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .push_i (rx_push),
      .data_i (rx_byte),
      .pop_i  (rx_pop),
      .data_o (rx_head),
      .empty_o(rx_empty),
      .full_o (rx_full)
   );

   uart_fifo tx_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .push_i (tx_push),
      .data_i (tx_byte),
      .pop_i  (tx_pop),
      .data_o (tx_head),
      .empty_o(tx_empty),
      .full_o (tx_full)
   );

   uart_rx rx (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .rxd_i      (uart_rxd_i),
      .div_i      (div),
      .byte_o     (rx_byte),
      .valid_o    (rx_push),
      .frame_err_o(frame_err)
   );

   uart_tx tx (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .byte_i (tx_head),
      .valid_i(!tx_empty),
      .div_i  (div),
      .ready_o(tx_ready),
      .txd_o  (uart_txd_o)
   );

endmodule

//--- uart_rx/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              rxd_i,
   input  logic [DIV_W-1:0]  div_i,
   output logic [DATA_W-1:0] byte_o,
   output logic              valid_o,
   output logic              frame_err_o
);

   logic [1:0]          rxd_sync;
   logic                rxd_s;
   logic [RX_ST_W-1:0]  state;
   logic [DIV_W-1:0]    div_q;
   logic [DIV_W-1:0]    cnt;
   logic [RX_BIT_W-1:0] bit_idx;
   logic [DATA_W-1:0]   shift;
   logic                half_tick;
   logic                bit_tick;

   // Line is asynchronous to clk_i
   assign rxd_s = rxd_sync[1];

   assign half_tick = (cnt == (div_q >> 1) - 1'b1);
   assign bit_tick  = (cnt == div_q - 1'b1);

   // Stop bit decides between a push and a framing error
   assign byte_o      = shift;
   assign valid_o     = (state == RX_STOP) && bit_tick && rxd_s;
   assign frame_err_o = (state == RX_STOP) && bit_tick && !rxd_s;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rxd_sync <= 2'b11;
         state    <= RX_IDLE;
         cnt      <= '0;
         bit_idx  <= '0;
      end else begin
         rxd_sync <= {rxd_sync[0], rxd_i};
         case (state)
            RX_IDLE: begin
               if (!rxd_s) begin
                  state <= RX_START;
                  cnt   <= '0;
               end
            end
            RX_START: begin
               if (half_tick) begin
                  // High at mid start means a glitch
                  state   <= rxd_s ? RX_IDLE : RX_DATA;
                  cnt     <= '0;
                  bit_idx <= '0;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_tick) begin
                  cnt     <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == RX_BIT_W'(DATA_W - 1)) begin
                     state <= RX_STOP;
                  end
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_tick) begin
                  cnt   <= '0;
                  state <= rxd_s ? RX_IDLE : RX_WAIT;
               end else begin
                  cnt <= cnt + 1'b1;
               end
            end
            RX_WAIT: begin
               // Hold off until the line is released
               if (rxd_s) begin
                  state <= RX_IDLE;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // Divisor is held for the whole frame
   always_ff @(posedge clk_i) begin
      if (state == RX_IDLE && !rxd_s) begin
         div_q <= div_i;
      end
      if (state == RX_DATA && bit_tick) begin
         shift <= {rxd_s, shift[DATA_W-1:1]};
      end
   end

endmodule

//--- uart_tx/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic [DATA_W-1:0] byte_i,
   input  logic              valid_i,
   input  logic [DIV_W-1:0]  div_i,
   output logic              ready_o,
   output logic              txd_o
);

   logic                  busy;
   logic                  txd_q;
   logic [FRAME_BITS-1:0] frame;
   logic [DIV_W-1:0]      div_q;
   logic [DIV_W-1:0]      cnt;
   logic [TX_BIT_W-1:0]   bit_idx;
   logic                  accept;
   logic                  bit_end;

   assign ready_o = !busy;
   assign txd_o   = txd_q;

   assign accept  = valid_i && !busy;
   assign bit_end = (cnt == div_q - 1'b1);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         busy    <= 1'b0;
         txd_q   <= 1'b1;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (accept) begin
         // Start bit goes out right away
         busy    <= 1'b1;
         txd_q   <= 1'b0;
         cnt     <= '0;
         bit_idx <= '0;
      end else if (busy) begin
         if (bit_end) begin
            cnt <= '0;
            if (bit_idx == TX_BIT_W'(FRAME_BITS - 1)) begin
               // End of stop bit, back to idle high
               busy  <= 1'b0;
               txd_q <= 1'b1;
            end else begin
               bit_idx <= bit_idx + 1'b1;
               txd_q   <= frame[1];
            end
         end else begin
            cnt <= cnt + 1'b1;
         end
      end
   end

   // Frame shifts right, LSB first on the line
   always_ff @(posedge clk_i) begin
      if (accept) begin
         frame <= {1'b1, byte_i, 1'b0};
         div_q <= div_i;
      end else if (busy && bit_end) begin
         frame <= {1'b1, frame[FRAME_BITS-1:1]};
      end
   end

endmodule
